//--- design/xv_pkg.sv
// video mode geometry, fetch schedule, register numbers, shared widths and sync state enum
package xv_pkg;

    // horizontal mode, the offscreen clocks sit on the left of each line
    localparam int H_VISIBLE       = 32;
    localparam int H_FRONT_PORCH   = 2;
    localparam int H_SYNC_PULSE    = 4;
    localparam int H_BACK_PORCH    = 2;
    localparam int H_TOTAL         = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
    localparam int OFFSCREEN_WIDTH = H_TOTAL - H_VISIBLE;   // 8 clocks before first visible

    // vertical mode, blanking lines follow the visible ones
    localparam int V_VISIBLE       = 16;
    localparam int V_FRONT_PORCH   = 1;
    localparam int V_SYNC_PULSE    = 2;
    localparam int V_BACK_PORCH    = 1;
    localparam int V_TOTAL         = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

    localparam logic H_SYNC_POLARITY = 1'b0;               // active low
    localparam logic V_SYNC_POLARITY = 1'b0;               // active low

    // tile geometry and memory timing
    localparam int TILE_WIDTH  = 8;
    localparam int FONT_LINES  = 8;
    localparam int MEM_LATENCY = 2;                         // select pulse to valid read data

    // vram fetch, font fetch, shifter load, then one clock each for shift and pixel register
    localparam int FETCH_LEAD  = 2 * MEM_LATENCY + 2;

    // tile phase of each request inside the fetch window
    localparam logic [2:0] PHASE_VRAM = 3'd0;
    localparam logic [2:0] PHASE_FONT = 3'(MEM_LATENCY);       // tile word arrives here
    localparam logic [2:0] PHASE_LOAD = 3'(2 * MEM_LATENCY);   // font byte arrives here

    typedef logic [10:0] count_t;                           // pixel or line count
    typedef logic [15:0] vram_addr_t;                       // vram word address
    typedef logic [15:0] vram_word_t;                       // {colour, tile}
    typedef logic [11:0] font_addr_t;                       // {bank, tile, tile line}
    typedef logic [7:0]  font_byte_t;                       // bit 7 is leftmost pixel
    typedef logic [3:0]  pal_index_t;
    typedef logic [1:0]  reg_num_t;

    // register numbers of the write-only config port
    localparam reg_num_t REG_DISPSTART = 2'd0;
    localparam reg_num_t REG_LINEWIDTH = 2'd1;
    localparam reg_num_t REG_FONTCTRL  = 2'd2;              // bank in data bit 0

    // order matters, each state steps to the next one
    typedef enum logic [1:0] {
        PRE_SYNC,
        SYNC,
        POST_SYNC,
        VISIBLE
    } video_state_e;

endpackage

//--- design/vgen_regs.sv
// vgen_regs: write-only text start, line width and font bank registers
module vgen_regs (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               reg_wr_i,       // write strobe, one write per clock
    input  xv_pkg::reg_num_t   reg_num_i,
    input  xv_pkg::vram_word_t reg_data_i,
    output xv_pkg::vram_addr_t text_start_o,   // first tile word of the frame
    output xv_pkg::vram_addr_t line_width_o,   // words per tile row
    output logic               font_bank_o     // upper or lower half of font ram
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            text_start_o <= '0;
            line_width_o <= xv_pkg::vram_addr_t'(xv_pkg::H_VISIBLE / xv_pkg::TILE_WIDTH);
            font_bank_o  <= 1'b0;
        end else if (reg_wr_i) begin
            case (reg_num_i)
                xv_pkg::REG_DISPSTART: begin
                    text_start_o <= reg_data_i;
                end
                xv_pkg::REG_LINEWIDTH: begin
                    line_width_o <= reg_data_i;
                end
                xv_pkg::REG_FONTCTRL: begin
                    font_bank_o  <= reg_data_i[0];
                end
                default: begin                  // unknown register, write dropped
                end
            endcase
        end
    end

endmodule

//--- design/raster_counter.sv
// raster_counter: pixel and line counters with line-end and frame-end strobes
module raster_counter (
    input  logic           clk,
    input  logic           reset_i,
    output xv_pkg::count_t h_count_o,      // 0 .. H_TOTAL-1, offscreen first
    output xv_pkg::count_t v_count_o,      // 0 .. V_TOTAL-1, visible first
    output logic           line_end_o,     // last clock of a line
    output logic           frame_end_o     // last clock of a frame
);

    assign line_end_o  = (h_count_o == xv_pkg::count_t'(xv_pkg::H_TOTAL - 1));
    assign frame_end_o = line_end_o && (v_count_o == xv_pkg::count_t'(xv_pkg::V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o <= '0;
            v_count_o <= '0;
        end else begin
            h_count_o <= h_count_o + 11'd1;
            if (line_end_o) begin
                h_count_o <= '0;
                v_count_o <= frame_end_o ? '0 : v_count_o + 11'd1;   // wrap at frame end
            end
        end
    end

endmodule

//--- design/sync_fsm.sv
// sync_fsm: horizontal and vertical sync state machines, fetch window, sync and enable outputs
module sync_fsm (
    input  logic           clk,
    input  logic           reset_i,
    input  xv_pkg::count_t h_count_i,
    input  xv_pkg::count_t v_count_i,
    input  logic           line_end_i,
    input  logic           frame_end_i,
    input  logic           enable_i,          // only looked at on frame end
    output logic           fetch_active_o,    // text fetch window
    output logic           hsync_o,
    output logic           vsync_o,
    output logic           de_o,
    output logic           text_en_o          // text output on for this frame
);

    xv_pkg::video_state_e h_state;
    xv_pkg::video_state_e v_state;
    xv_pkg::count_t       h_last;            // last count of current h state
    xv_pkg::count_t       v_last;            // last line of current v state

    // boundary counts of each state
    always_comb begin
        case (h_state)
            xv_pkg::PRE_SYNC:  h_last = xv_pkg::count_t'(xv_pkg::H_FRONT_PORCH - 1);
            xv_pkg::SYNC:      h_last = xv_pkg::count_t'(xv_pkg::H_FRONT_PORCH
                                                         + xv_pkg::H_SYNC_PULSE - 1);
            xv_pkg::POST_SYNC: h_last = xv_pkg::count_t'(xv_pkg::OFFSCREEN_WIDTH - 1);
            default:           h_last = xv_pkg::count_t'(xv_pkg::H_TOTAL - 1);
        endcase
        case (v_state)
            xv_pkg::PRE_SYNC:  v_last = xv_pkg::count_t'(xv_pkg::V_VISIBLE
                                                         + xv_pkg::V_FRONT_PORCH - 1);
            xv_pkg::SYNC:      v_last = xv_pkg::count_t'(xv_pkg::V_VISIBLE + xv_pkg::V_FRONT_PORCH
                                                         + xv_pkg::V_SYNC_PULSE - 1);
            xv_pkg::POST_SYNC: v_last = xv_pkg::count_t'(xv_pkg::V_TOTAL - 1);
            default:           v_last = xv_pkg::count_t'(xv_pkg::V_VISIBLE - 1);
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state        <= xv_pkg::PRE_SYNC;
            v_state        <= xv_pkg::VISIBLE;
            fetch_active_o <= 1'b0;
            text_en_o      <= 1'b0;                      // first frame always blank
            hsync_o        <= ~xv_pkg::H_SYNC_POLARITY;
            vsync_o        <= ~xv_pkg::V_SYNC_POLARITY;
            de_o           <= 1'b0;
        end else begin
            if (h_count_i == h_last) begin
                h_state <= xv_pkg::video_state_e'(h_state + 2'd1);
            end
            if (line_end_i && (v_count_i == v_last)) begin
                v_state <= xv_pkg::video_state_e'(v_state + 2'd1);
            end

            // window runs from FETCH_LEAD clocks ahead of visible to end of line
            if (h_count_i == xv_pkg::count_t'(xv_pkg::H_TOTAL - 1)) begin
                fetch_active_o <= 1'b0;
            end else if (text_en_o && (v_state == xv_pkg::VISIBLE) &&
                         (h_count_i == xv_pkg::count_t'(xv_pkg::OFFSCREEN_WIDTH
                                                        - xv_pkg::FETCH_LEAD))) begin
                fetch_active_o <= 1'b1;
            end

            if (frame_end_i) begin
                text_en_o <= enable_i;
            end

            // registered outputs trail the states by one clock, as does the pixel pipe
            hsync_o <= (h_state == xv_pkg::SYNC) ? xv_pkg::H_SYNC_POLARITY
                                                 : ~xv_pkg::H_SYNC_POLARITY;
            vsync_o <= (v_state == xv_pkg::SYNC) ? xv_pkg::V_SYNC_POLARITY
                                                 : ~xv_pkg::V_SYNC_POLARITY;
            de_o    <= text_en_o && (h_state == xv_pkg::VISIBLE) && (v_state == xv_pkg::VISIBLE);
        end
    end

endmodule

//--- design/text_fetch.sv
// text_fetch: tile phase timer, text and line addressing, tile line and memory request sequencing
module text_fetch (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               fetch_active_i,
    input  logic               line_end_i,
    input  logic               frame_end_i,
    input  xv_pkg::vram_addr_t text_start_i,
    input  xv_pkg::vram_addr_t line_width_i,
    input  logic               font_bank_i,
    input  xv_pkg::vram_word_t vram_data_i,      // valid MEM_LATENCY clocks after select
    input  xv_pkg::font_byte_t fontram_data_i,
    output logic               vram_sel_o,
    output xv_pkg::vram_addr_t vram_addr_o,
    output logic               fontram_sel_o,
    output xv_pkg::font_addr_t fontram_addr_o,
    output logic               load_o,           // shifter takes font line and colour
    output xv_pkg::font_byte_t font_line_o,
    output byte                colour_o          // {background, foreground}
);

    logic [2:0]         tile_x;                  // phase within the tile, wraps every 8
    logic [2:0]         tile_y;                  // font line within the tile row
    xv_pkg::vram_addr_t text_addr;               // next tile word to fetch
    xv_pkg::vram_addr_t line_addr;               // first tile word of the tile row
    logic               last_font_line;

    assign last_font_line = (tile_y == 3'(xv_pkg::FONT_LINES - 1));

    // requests overlap, next tile word is fetched while the shifter drains the current one
    always_comb begin
        vram_sel_o     = fetch_active_i && (tile_x == xv_pkg::PHASE_VRAM);
        vram_addr_o    = text_addr;
        fontram_sel_o  = fetch_active_i && (tile_x == xv_pkg::PHASE_FONT);
        fontram_addr_o = {font_bank_i, vram_data_i[7:0], tile_y};   // tile byte straight off vram
        load_o         = fetch_active_i && (tile_x == xv_pkg::PHASE_LOAD);
        font_line_o    = fontram_data_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tile_x    <= 3'd0;
            tile_y    <= 3'd0;
            text_addr <= '0;
            line_addr <= '0;
        end else begin
            tile_x <= fetch_active_i ? tile_x + 3'd1 : 3'd0;   // held at 0 until window opens
            if (vram_sel_o) begin
                text_addr <= text_addr + 16'd1;
            end

            if (line_end_i) begin
                text_addr <= line_addr;                    // same row again
                tile_y    <= tile_y + 3'd1;
                if (last_font_line) begin
                    tile_y    <= 3'd0;
                    line_addr <= line_addr + line_width_i;
                    text_addr <= line_addr + line_width_i;
                end
            end

            // frame end wins over line end
            if (frame_end_i) begin
                tile_y    <= 3'd0;
                text_addr <= text_start_i;
                line_addr <= text_start_i;
            end
        end
    end

    // colour half of the tile word, held until the load two phases on
    always_ff @(posedge clk) begin
        if (fetch_active_i && (tile_x == xv_pkg::PHASE_FONT)) begin
            colour_o <= vram_data_i[15:8];
        end
    end

endmodule

//--- design/pixel_shifter.sv
// pixel_shifter: font line shift register, tile colour latch and palette index register
module pixel_shifter (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               load_i,
    input  xv_pkg::font_byte_t font_line_i,
    input  byte                colour_i,
    output xv_pkg::pal_index_t pal_index_o
);

    xv_pkg::font_byte_t font_shift;    // bit 7 is the current pixel
    byte                colour;        // fg low nibble, bg high nibble

    always_ff @(posedge clk) begin
        if (reset_i) begin
            font_shift  <= '0;
            colour      <= '0;         // keeps the index at 0 until the first tile
            pal_index_o <= '0;
        end else begin
            if (load_i) begin
                font_shift <= font_line_i;
                colour     <= colour_i;
            end else begin
                font_shift <= {font_shift[6:0], 1'b0};
            end
            pal_index_o <= font_shift[7] ? colour[3:0] : colour[7:4];
        end
    end

endmodule

//--- design/video_gen.sv
// video_gen: top level joining registers, raster counter, sync FSM, text fetch and pixel shifter
module video_gen (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               enable_i,          // text on or off from the next frame
    input  logic               reg_wr_i,
    input  xv_pkg::reg_num_t   reg_num_i,
    input  xv_pkg::vram_word_t reg_data_i,
    input  xv_pkg::vram_word_t vram_data_i,
    input  xv_pkg::font_byte_t fontram_data_i,
    output logic               vram_sel_o,
    output xv_pkg::vram_addr_t vram_addr_o,
    output logic               fontram_sel_o,
    output xv_pkg::font_addr_t fontram_addr_o,
    output xv_pkg::pal_index_t pal_index_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               de_o
);

    xv_pkg::count_t     h_count;
    xv_pkg::count_t     v_count;
    logic               line_end;
    logic               frame_end;
    logic               fetch_active;
    xv_pkg::vram_addr_t text_start;
    xv_pkg::vram_addr_t line_width;
    logic               font_bank;
    logic               load;
    xv_pkg::font_byte_t font_line;
    byte                colour;

    vgen_regs u_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .reg_wr_i     (reg_wr_i),
        .reg_num_i    (reg_num_i),
        .reg_data_i   (reg_data_i),
        .text_start_o (text_start),
        .line_width_o (line_width),
        .font_bank_o  (font_bank)
    );

    raster_counter u_raster (
        .clk         (clk),
        .reset_i     (reset_i),
        .h_count_o   (h_count),
        .v_count_o   (v_count),
        .line_end_o  (line_end),
        .frame_end_o (frame_end)
    );

    sync_fsm u_sync (
        .clk            (clk),
        .reset_i        (reset_i),
        .h_count_i      (h_count),
        .v_count_i      (v_count),
        .line_end_i     (line_end),
        .frame_end_i    (frame_end),
        .enable_i       (enable_i),
        .fetch_active_o (fetch_active),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .de_o           (de_o),
        .text_en_o      ()                    // already folded into de and the fetch window
    );

    text_fetch u_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .fetch_active_i (fetch_active),
        .line_end_i     (line_end),
        .frame_end_i    (frame_end),
        .text_start_i   (text_start),
        .line_width_i   (line_width),
        .font_bank_i    (font_bank),
        .vram_data_i    (vram_data_i),
        .fontram_data_i (fontram_data_i),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .fontram_sel_o  (fontram_sel_o),
        .fontram_addr_o (fontram_addr_o),
        .load_o         (load),
        .font_line_o    (font_line),
        .colour_o       (colour)
    );

    pixel_shifter u_shifter (
        .clk         (clk),
        .reset_i     (reset_i),
        .load_i      (load),
        .font_line_i (font_line),
        .colour_i    (colour),
        .pal_index_o (pal_index_o)
    );

endmodule

//--- verif/vgen_mem_model.sv
// vgen_mem_model: vram and font ram models answering select pulses after MEM_LATENCY clocks
module vgen_mem_model (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               vram_sel_i,
    input  xv_pkg::vram_addr_t vram_addr_i,
    output xv_pkg::vram_word_t vram_data_o,      // held until the next answered read
    input  logic               fontram_sel_i,
    input  xv_pkg::font_addr_t fontram_addr_i,
    output xv_pkg::font_byte_t fontram_data_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int STAGES = xv_pkg::MEM_LATENCY - 1;   // address stages ahead of the read register

    xv_pkg::vram_word_t vram_mem [0:65535];            // preloaded by the testbench at time 0
    xv_pkg::font_byte_t font_mem [0:4095];             // {bank, tile, line} addressed

    logic               vram_sel_q  [STAGES];
    xv_pkg::vram_addr_t vram_addr_q [STAGES];
    logic               font_sel_q  [STAGES];
    xv_pkg::font_addr_t font_addr_q [STAGES];

    always @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < STAGES; s++) begin
                vram_sel_q[s] <= 1'b0;
                font_sel_q[s] <= 1'b0;
            end
            vram_data_o    <= '0;
            fontram_data_o <= '0;
        end else begin
            vram_sel_q[0]  <= vram_sel_i;             // first stage takes the request
            vram_addr_q[0] <= vram_addr_i;
            font_sel_q[0]  <= fontram_sel_i;
            font_addr_q[0] <= fontram_addr_i;
            for (int s = 1; s < STAGES; s++) begin
                vram_sel_q[s]  <= vram_sel_q[s - 1];
                vram_addr_q[s] <= vram_addr_q[s - 1];
                font_sel_q[s]  <= font_sel_q[s - 1];
                font_addr_q[s] <= font_addr_q[s - 1];
            end
            if (vram_sel_q[STAGES - 1]) begin
                vram_data_o <= vram_mem[vram_addr_q[STAGES - 1]];      // valid MEM_LATENCY on
            end
            if (font_sel_q[STAGES - 1]) begin
                fontram_data_o <= font_mem[font_addr_q[STAGES - 1]];
            end
        end
    end

endmodule

//--- verif/tb_video_gen.sv
// tb_video_gen: clock, reset, register stimulus table, frame checks, watchdog
module tb_video_gen;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int     CLK_PERIOD   = 10;
    localparam int     RESET_CYCLES = 10;
    localparam int     FRAME_CYCLES = xv_pkg::H_TOTAL * xv_pkg::V_TOTAL;
    localparam int     NUM_ROWS     = 6;
    localparam longint WATCHDOG_NS  = longint'(NUM_ROWS) * 4 * FRAME_CYCLES * CLK_PERIOD;

    // defaults, start move, wide rows, bank 1, text off, address wrap
    localparam xv_pkg::vram_addr_t ROW_START [NUM_ROWS] = '{16'h0000, 16'h0123, 16'h0400,
                                                            16'h2000, 16'h0050, 16'hfffe};
    localparam xv_pkg::vram_addr_t ROW_WIDTH [NUM_ROWS] = '{16'd4, 16'd4, 16'd16,
                                                            16'd7, 16'd4, 16'd5};
    localparam logic ROW_BANK   [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
    localparam logic ROW_ENABLE [NUM_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};

    logic               clk;
    logic               reset_i;
    logic               enable_i;
    logic               reg_wr_i;
    xv_pkg::reg_num_t   reg_num_i;
    xv_pkg::vram_word_t reg_data_i;
    xv_pkg::vram_word_t vram_data_i;
    xv_pkg::font_byte_t fontram_data_i;
    logic               vram_sel_o;
    xv_pkg::vram_addr_t vram_addr_o;
    logic               fontram_sel_o;
    xv_pkg::font_addr_t fontram_addr_o;
    xv_pkg::pal_index_t pal_index_o;
    logic               hsync_o;
    logic               vsync_o;
    logic               de_o;

    video_gen u_video_gen (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (enable_i),
        .reg_wr_i       (reg_wr_i),
        .reg_num_i      (reg_num_i),
        .reg_data_i     (reg_data_i),
        .vram_data_i    (vram_data_i),
        .fontram_data_i (fontram_data_i),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .fontram_sel_o  (fontram_sel_o),
        .fontram_addr_o (fontram_addr_o),
        .pal_index_o    (pal_index_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .de_o           (de_o)
    );

    vgen_mem_model u_mem (
        .clk            (clk),
        .reset_i        (reset_i),
        .vram_sel_i     (vram_sel_o),
        .vram_addr_i    (vram_addr_o),
        .vram_data_o    (vram_data_i),
        .fontram_sel_i  (fontram_sel_o),
        .fontram_addr_i (fontram_addr_o),
        .fontram_data_o (fontram_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fill_memories();
        logic [31:0] state;
        state = 32'heaf4;
        for (int i = 0; i < 65536; i++) begin
            state = xorshift32(state);
            u_mem.vram_mem[xv_pkg::vram_addr_t'(i)] = state[15:0] ^ 16'(i);   // {colour, tile}
        end
        for (int i = 0; i < 4096; i++) begin
            state = xorshift32(state);
            u_mem.font_mem[xv_pkg::font_addr_t'(i)] = state[31:24] ^ 8'(i) ^ 8'(i >> 8);
        end
    endtask

    // visible pixel (x, y) from tile word, font line and colour nibbles
    function automatic xv_pkg::pal_index_t expected_pixel(xv_pkg::count_t x, xv_pkg::count_t y,
            xv_pkg::vram_addr_t start, xv_pkg::vram_addr_t width, logic bank);
        xv_pkg::vram_addr_t addr;
        xv_pkg::vram_word_t word;
        xv_pkg::font_byte_t line_bits;
        logic [2:0]         bit_sel;
        addr      = start + width * xv_pkg::vram_addr_t'(y / xv_pkg::FONT_LINES)
                    + xv_pkg::vram_addr_t'(x / xv_pkg::TILE_WIDTH);
        word      = u_mem.vram_mem[addr];
        line_bits = u_mem.font_mem[{bank, word[7:0], 3'(y % xv_pkg::FONT_LINES)}];
        bit_sel   = 3'(7 - (x % xv_pkg::TILE_WIDTH));             // bit 7 is leftmost
        return line_bits[bit_sel] ? word[11:8] : word[15:12];     // fg low nibble, bg high
    endfunction

    task automatic report_failure();
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first failed check");
    endtask

    task automatic check_pal(string name, xv_pkg::pal_index_t got, xv_pkg::pal_index_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_count(string name, xv_pkg::count_t got, xv_pkg::count_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic write_reg(xv_pkg::reg_num_t num, xv_pkg::vram_word_t data);
        @(posedge clk);
        reg_wr_i   <= 1'b1;
        reg_num_i  <= num;
        reg_data_i <= data;
        @(posedge clk);
        reg_wr_i   <= 1'b0;
    endtask

    // returns on the falling edge inside the last clock of a frame
    task automatic wait_frame_end();
        @(negedge clk);
        while (u_video_gen.frame_end !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // one whole frame, sampled on falling edges where outputs are settled
    task automatic inspect_frame(xv_pkg::vram_addr_t start, xv_pkg::vram_addr_t width,
            logic bank, logic enabled);
        logic           hs;
        logic           vs;
        logic           hs_q;
        logic           vs_q;
        logic           de_q;
        int             hs_start;
        xv_pkg::count_t hs_width;
        xv_pkg::count_t vs_width;
        xv_pkg::count_t hs_pulses;
        xv_pkg::count_t vs_pulses;
        xv_pkg::count_t de_cnt;
        xv_pkg::count_t de_lines;
        hs_q      = (hsync_o == xv_pkg::H_SYNC_POLARITY);
        vs_q      = (vsync_o == xv_pkg::V_SYNC_POLARITY);
        de_q      = de_o;
        hs_start  = 0;
        hs_width  = '0;
        vs_width  = '0;
        hs_pulses = '0;
        vs_pulses = '0;
        de_cnt    = '0;
        de_lines  = '0;
        for (int cyc = 0; cyc < FRAME_CYCLES; cyc++) begin
            @(negedge clk);
            hs = (hsync_o == xv_pkg::H_SYNC_POLARITY);
            vs = (vsync_o == xv_pkg::V_SYNC_POLARITY);
            if (hs && !hs_q) begin
                if (hs_pulses != 0) begin
                    check_count("hsync_o period", xv_pkg::count_t'(cyc - hs_start),
                                xv_pkg::count_t'(xv_pkg::H_TOTAL));
                end
                hs_start  = cyc;
                hs_pulses = hs_pulses + 11'd1;
                hs_width  = '0;
            end
            if (hs) hs_width = hs_width + 11'd1;
            if (!hs && hs_q) begin
                check_count("hsync_o width", hs_width, xv_pkg::count_t'(xv_pkg::H_SYNC_PULSE));
            end
            if (vs && !vs_q) begin
                vs_pulses = vs_pulses + 11'd1;
                vs_width  = '0;
            end
            if (vs) vs_width = vs_width + 11'd1;
            if (!vs && vs_q) begin
                check_count("vsync_o width", vs_width,
                            xv_pkg::count_t'(xv_pkg::V_SYNC_PULSE * xv_pkg::H_TOTAL));
            end
            if (!enabled) begin                            // blank frame, no bus traffic
                check_flag("de_o", de_o, 1'b0);
                check_flag("vram_sel_o", vram_sel_o, 1'b0);
                check_flag("fontram_sel_o", fontram_sel_o, 1'b0);
            end
            if (de_o) begin                                // k-th de cycle shows column k
                check_pal($sformatf("pal_index_o x%0d y%0d", de_cnt, de_lines), pal_index_o,
                          expected_pixel(de_cnt, de_lines, start, width, bank));
                de_cnt = de_cnt + 11'd1;
            end else if (de_q) begin
                check_count("de_o run", de_cnt, xv_pkg::count_t'(xv_pkg::H_VISIBLE));
                de_lines = de_lines + 11'd1;
                de_cnt   = '0;
            end
            hs_q = hs;
            vs_q = vs;
            de_q = de_o;
        end
        check_count("hsync_o pulses", hs_pulses, xv_pkg::count_t'(xv_pkg::V_TOTAL));
        check_count("vsync_o pulses", vs_pulses, xv_pkg::count_t'(1));
        check_count("de_o lines", de_lines, xv_pkg::count_t'(enabled ? xv_pkg::V_VISIBLE : 0));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish in the time allowed for the table");
        report_failure();
    end

    initial begin
        reset_i    <= 1'b1;
        enable_i   <= 1'b0;
        reg_wr_i   <= 1'b0;
        reg_num_i  <= '0;
        reg_data_i <= '0;
        fill_memories();
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            write_reg(xv_pkg::REG_DISPSTART, ROW_START[r]);
            write_reg(xv_pkg::REG_LINEWIDTH, ROW_WIDTH[r]);
            write_reg(xv_pkg::REG_FONTCTRL, {15'd0, ROW_BANK[r]});
            write_reg(2'd3, 16'hffff);                     // unknown number, must be dropped
            @(posedge clk);
            enable_i <= ROW_ENABLE[r];
            wait_frame_end();                              // enable and start taken here
            wait_frame_end();
            inspect_frame(ROW_START[r], ROW_WIDTH[r], ROW_BANK[r], ROW_ENABLE[r]);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- sim.f
design/xv_pkg.sv
design/vgen_regs.sv
design/raster_counter.sv
design/sync_fsm.sv
design/text_fetch.sv
design/pixel_shifter.sv
design/video_gen.sv
verif/vgen_mem_model.sv
verif/tb_video_gen.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_video_gen
FILELIST = sim.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
